/* hw/rx_chain_config.svh */
// build-time sizing for the receive chain
// buffer depth should be a power of two, channel count at least two
// record width is channel id + timestamp + sample, keep it at 32 bits

`ifndef RX_CHAIN_CONFIG_SVH
`define RX_CHAIN_CONFIG_SVH

// physical and logical channel count
`define RX_CHANNELS 2

// bits per adc sample, two's complement
`define RX_SAMPLE_WIDTH 16

// timestamp bits stored in each record
`define RX_TSTAMP_WIDTH 15

// records held by the capture buffer
`define RX_BUFFER_DEPTH 64

`endif

/* hw/rx_chain_pkg.sv */
// shared types for the receive chain
// widths follow the macros in the config header

package rx_chain_pkg;

`include "rx_chain_config.svh"

  typedef logic [`RX_SAMPLE_WIDTH-1:0] sample_t;          // one sample, signed view
  typedef logic [`RX_TSTAMP_WIDTH-1:0] tstamp_t;          // sample index since start
  typedef logic [$clog2(`RX_CHANNELS)-1:0] chan_id_t;     // logical channel number
  typedef logic [$clog2(2*`RX_CHANNELS)-1:0] src_sel_t;   // raw sources low, diff high

  // channel id on top, timestamp, then sample in the low bits
  typedef logic [$bits(chan_id_t)+$bits(tstamp_t)+$bits(sample_t)-1:0] record_t;

  // capture buffer modes
  typedef enum logic [1:0] {
    IDLE,
    CAPTURE,
    READOUT
  } buf_state_t;

  // output handshake phases
  typedef enum logic [1:0] {
    WAIT_DATA,
    REQ_HIGH,
    WAIT_ACK_LOW
  } hs_state_t;

endpackage

/* hw/sample_differentiator.sv */
// first difference per channel, wraps at the sample width
// raw samples come out through the same register stage as the differences

`timescale 1ns/1ps
`include "rx_chain_config.svh"

module sample_differentiator (
  input  logic                                     adc_clk,
  input  logic                                     adc_reset,
  input  rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] in_data_i,
  input  logic                                     in_valid_i,
  output rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] raw_data_o,
  output rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] diff_data_o,
  output logic                                     out_valid_o
);

  import rx_chain_pkg::*;

  sample_t [`RX_CHANNELS-1:0] prev_q;  // last valid sample per channel

  ////////////////////////////////////////////////////////////
  // history and valid
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      prev_q      <= '0;  // first difference is against zero
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= in_valid_i;
      if (in_valid_i) begin
        prev_q <= in_data_i;  // only real samples count as history
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // data path, one cycle
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      raw_data_o[c]  <= in_data_i[c];               // aligned raw copy
      diff_data_o[c] <= in_data_i[c] - prev_q[c];   // modulo 2^width
    end
  end

endmodule

/* hw/channel_mux.sv */
// picks one of 2*channels sources for every logical channel
// select values past the last source give zero data

`timescale 1ns/1ps
`include "rx_chain_config.svh"

module channel_mux (
  input  logic                                       adc_clk,
  input  logic                                       adc_reset,
  input  rx_chain_pkg::sample_t  [`RX_CHANNELS-1:0]  raw_data_i,
  input  rx_chain_pkg::sample_t  [`RX_CHANNELS-1:0]  diff_data_i,
  input  logic                                       in_valid_i,
  input  rx_chain_pkg::src_sel_t [`RX_CHANNELS-1:0]  mux_config_i,
  output rx_chain_pkg::sample_t  [`RX_CHANNELS-1:0]  out_data_o,
  output logic                                       out_valid_o
);

  import rx_chain_pkg::*;

  localparam int NUM_SRC = 2 * `RX_CHANNELS;

  sample_t [NUM_SRC-1:0] sources;  // raw in the low half, diff in the high half

  assign sources = {diff_data_i, raw_data_i};

  ////////////////////////////////////////////////////////////
  // valid follows the data by one cycle
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= in_valid_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // selection, registered
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      if (int'(mux_config_i[c]) < NUM_SRC) begin
        out_data_o[c] <= sources[mux_config_i[c]];
      end else begin
        out_data_o[c] <= '0;  // unused select codes
      end
    end
  end

endmodule

/* hw/sample_discriminator.sv */
// hysteresis event flag per channel, signed compare against both thresholds
// set wins if high is below low; thresholds held stable while idle

`timescale 1ns/1ps
`include "rx_chain_config.svh"

module sample_discriminator (
  input  logic                                     adc_clk,
  input  logic                                     adc_reset,
  input  rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] in_data_i,
  input  logic                                     in_valid_i,
  input  rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] thresh_high_i,
  input  rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] thresh_low_i,
  output rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] out_data_o,
  output logic                  [`RX_CHANNELS-1:0] out_keep_o,
  output logic                                     out_valid_o
);

  import rx_chain_pkg::*;

  logic [`RX_CHANNELS-1:0] flag_q;     // inside an event
  logic [`RX_CHANNELS-1:0] flag_next;

  ////////////////////////////////////////////////////////////
  // flag update rule
  ////////////////////////////////////////////////////////////
  always_comb begin
    flag_next = flag_q;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      if ($signed(in_data_i[c]) > $signed(thresh_high_i[c])) begin
        flag_next[c] = 1'b1;  // event opens
      end else if ($signed(in_data_i[c]) < $signed(thresh_low_i[c])) begin
        flag_next[c] = 1'b0;  // event closes
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      flag_q      <= '0;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= in_valid_i;
      if (in_valid_i) begin
        flag_q <= flag_next;  // gaps leave the flag alone
      end
    end
  end

  // keep is the flag after this sample's update, same stage as the data
  assign out_keep_o = flag_q;

  always_ff @(posedge adc_clk) begin
    out_data_o <= in_data_i;
  end

endmodule

/* hw/capture_buffer.sv */
// record store for one capture, written in channel order, read from index 0
// start/trigger only act in idle; timestamp wraps after 2^15 valid samples

`timescale 1ns/1ps
`include "rx_chain_config.svh"

module capture_buffer (
  input  logic                                     adc_clk,
  input  logic                                     adc_reset,
  input  rx_chain_pkg::sample_t [`RX_CHANNELS-1:0] in_data_i,
  input  logic                  [`RX_CHANNELS-1:0] in_keep_i,
  input  logic                                     in_valid_i,
  input  logic                                     start_i,
  input  logic                                     trigger_i,
  input  logic                                     stop_i,
  output logic                                     capture_active_o,
  output logic                                     capture_done_o,
  output logic                                     rd_avail_o,
  output rx_chain_pkg::record_t                    rd_data_o,
  output logic                                     rd_last_o,
  input  logic                                     rd_pop_i
);

  import rx_chain_pkg::*;

  localparam int DEPTH  = `RX_BUFFER_DEPTH;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int CNT_W  = $clog2(DEPTH + 1);  // count must reach DEPTH

  buf_state_t                          state_q;
  tstamp_t                             tstamp_q;     // valid samples since start
  logic [CNT_W-1:0]                    wr_count_q;   // records stored
  logic [CNT_W-1:0]                    wr_ptr;       // count after this cycle's writes
  logic [CNT_W-1:0]                    rd_idx_q;
  logic [`RX_CHANNELS-1:0]             wr_en;
  logic [`RX_CHANNELS-1:0][ADDR_W-1:0] wr_addr;
  record_t                             mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // write slots, kept channels packed in rising order
  ////////////////////////////////////////////////////////////
  always_comb begin
    wr_ptr = wr_count_q;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      wr_en[c]   = (state_q == CAPTURE) && in_valid_i && in_keep_i[c]
                   && (wr_ptr < CNT_W'(DEPTH));  // drop what does not fit
      wr_addr[c] = wr_ptr[ADDR_W-1:0];
      if (wr_en[c]) begin
        wr_ptr = wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      if (wr_en[c]) begin
        mem[wr_addr[c]] <= {chan_id_t'(c), tstamp_q, in_data_i[c]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // capture fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state_q        <= IDLE;
      tstamp_q       <= '0;
      wr_count_q     <= '0;
      rd_idx_q       <= '0;
      capture_done_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i || trigger_i) begin
            state_q        <= CAPTURE;
            tstamp_q       <= '0;
            wr_count_q     <= '0;
            rd_idx_q       <= '0;
            capture_done_o <= 1'b0;  // done holds until a new start
          end
        end
        CAPTURE: begin
          if (in_valid_i) begin
            tstamp_q <= tstamp_q + 1'b1;
          end
          wr_count_q <= wr_ptr;
          if (stop_i || wr_ptr == CNT_W'(DEPTH)) begin  // stop or full
            state_q        <= READOUT;
            capture_done_o <= 1'b1;
          end
        end
        READOUT: begin
          if (rd_idx_q == wr_count_q) begin
            state_q <= IDLE;  // everything popped, or nothing stored
          end else if (rd_pop_i) begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////
  assign capture_active_o = (state_q == CAPTURE);
  assign rd_avail_o       = (state_q == READOUT) && (rd_idx_q < wr_count_q);
  assign rd_data_o        = mem[rd_idx_q[ADDR_W-1:0]];
  assign rd_last_o        = ((rd_idx_q + 1'b1) == wr_count_q);  // final written record

endmodule

/* hw/readout_port.sv */
// four-phase req/ack sender, data and last stable while req is high
// last record is popped only after its handshake closes

`timescale 1ns/1ps

module readout_port (
  input  logic                  adc_clk,
  input  logic                  adc_reset,
  input  logic                  rd_avail_i,
  input  rx_chain_pkg::record_t rd_data_i,
  input  logic                  rd_last_i,
  output logic                  rd_pop_o,
  output logic                  out_req_o,
  output rx_chain_pkg::record_t out_data_o,
  output logic                  out_last_o,
  input  logic                  out_ack_i
);

  import rx_chain_pkg::*;

  hs_state_t state_q;
  logic      take;  // record accepted this cycle

  assign take = (state_q == WAIT_DATA) && rd_avail_i && !out_ack_i;

  // pop early records on take; hold the last one so the buffer stays in readout
  assign rd_pop_o = (take && !rd_last_i)
                    || ((state_q == WAIT_ACK_LOW) && !out_ack_i && out_last_o);

  ////////////////////////////////////////////////////////////
  // handshake fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state_q   <= WAIT_DATA;
      out_req_o <= 1'b0;
    end else begin
      case (state_q)
        WAIT_DATA: begin
          if (take) begin
            out_req_o <= 1'b1;
            state_q   <= REQ_HIGH;
          end
        end
        REQ_HIGH: begin
          if (out_ack_i) begin
            out_req_o <= 1'b0;   // phase 3
            state_q   <= WAIT_ACK_LOW;
          end
        end
        WAIT_ACK_LOW: begin
          if (!out_ack_i) begin
            state_q <= WAIT_DATA;  // cycle complete
          end
        end
        default: state_q <= WAIT_DATA;
      endcase
    end
  end

  // record latch
  always_ff @(posedge adc_clk) begin
    if (take) begin
      out_data_o <= rd_data_i;
      out_last_o <= rd_last_i;
    end
  end

endmodule

/* hw/rx_chain_top.sv */
// receive chain, adc samples in, timestamped records out over req/ack
// all config ports in adc_clk domain and held stable between captures

`timescale 1ns/1ps
`include "rx_chain_config.svh"

module rx_chain_top (
  input  logic                                       adc_clk,
  input  logic                                       adc_reset,
  input  rx_chain_pkg::sample_t  [`RX_CHANNELS-1:0]  adc_data_i,
  input  logic                                       adc_valid_i,
  input  rx_chain_pkg::src_sel_t [`RX_CHANNELS-1:0]  mux_config_i,
  input  rx_chain_pkg::sample_t  [`RX_CHANNELS-1:0]  thresh_high_i,
  input  rx_chain_pkg::sample_t  [`RX_CHANNELS-1:0]  thresh_low_i,
  input  logic                                       start_i,
  input  logic                                       trigger_i,
  input  logic                                       stop_i,
  output logic                                       capture_active_o,
  output logic                                       capture_done_o,
  output logic                                       out_req_o,
  output rx_chain_pkg::record_t                      out_data_o,
  output logic                                       out_last_o,
  input  logic                                       out_ack_i
);

  import rx_chain_pkg::*;

  ////////////////////////////////////////////////////////////
  // stage signals, three cycles from adc to buffer
  ////////////////////////////////////////////////////////////
  sample_t [`RX_CHANNELS-1:0] raw_data;
  sample_t [`RX_CHANNELS-1:0] diff_data;
  logic                       diff_valid;
  sample_t [`RX_CHANNELS-1:0] mux_data;
  logic                       mux_valid;
  sample_t [`RX_CHANNELS-1:0] disc_data;
  logic    [`RX_CHANNELS-1:0] disc_keep;
  logic                       disc_valid;
  logic                       rd_avail;    // buffer to readout
  record_t                    rd_data;
  logic                       rd_last;
  logic                       rd_pop;

  sample_differentiator u_diff (
    .adc_clk, .adc_reset,
    .in_data_i(adc_data_i), .in_valid_i(adc_valid_i),
    .raw_data_o(raw_data), .diff_data_o(diff_data), .out_valid_o(diff_valid)
  );

  channel_mux u_mux (
    .adc_clk, .adc_reset,
    .raw_data_i(raw_data), .diff_data_i(diff_data), .in_valid_i(diff_valid),
    .mux_config_i, .out_data_o(mux_data), .out_valid_o(mux_valid)
  );

  sample_discriminator u_disc (
    .adc_clk, .adc_reset,
    .in_data_i(mux_data), .in_valid_i(mux_valid),
    .thresh_high_i, .thresh_low_i,
    .out_data_o(disc_data), .out_keep_o(disc_keep), .out_valid_o(disc_valid)
  );

  capture_buffer u_buf (
    .adc_clk, .adc_reset,
    .in_data_i(disc_data), .in_keep_i(disc_keep), .in_valid_i(disc_valid),
    .start_i, .trigger_i, .stop_i,
    .capture_active_o, .capture_done_o,
    .rd_avail_o(rd_avail), .rd_data_o(rd_data), .rd_last_o(rd_last), .rd_pop_i(rd_pop)
  );

  readout_port u_out (
    .adc_clk, .adc_reset,
    .rd_avail_i(rd_avail), .rd_data_i(rd_data), .rd_last_i(rd_last), .rd_pop_o(rd_pop),
    .out_req_o, .out_data_o, .out_last_o, .out_ack_i
  );

endmodule

/* tb/rx_chain_tb.sv */
// self-checking testbench for the receive chain, mux settings assume two channels
// expected records come from a sample-level model fed with every driven sample

`timescale 1ns/1ps
`include "rx_chain_config.svh"

module rx_chain_tb;

  import rx_chain_pkg::*;

  logic                        adc_clk;
  logic                        adc_reset;
  sample_t  [`RX_CHANNELS-1:0] adc_data_i;
  logic                        adc_valid_i;
  src_sel_t [`RX_CHANNELS-1:0] mux_config_i;
  sample_t  [`RX_CHANNELS-1:0] thresh_high_i;
  sample_t  [`RX_CHANNELS-1:0] thresh_low_i;
  logic                        start_i;
  logic                        trigger_i;
  logic                        stop_i;
  logic                        capture_active_o;
  logic                        capture_done_o;
  logic                        out_req_o;
  record_t                     out_data_o;
  logic                        out_last_o;
  logic                        out_ack_i;

  // model state, lives across captures like the chain does
  record_t                     exp_q[$];
  sample_t  [`RX_CHANNELS-1:0] m_prev;       // last sample per physical channel
  logic     [`RX_CHANNELS-1:0] m_flag;       // event flag per logical channel
  tstamp_t                     m_ts;
  int                          m_count;
  logic                        m_capturing;

  integer seed;
  int     delay_tab [256];                   // ack delays, 0 to 5 cycles
  int     ack_scale;                         // stretches delays for back-pressure
  int     main_errs;
  int     cmp_errs;
  int     check_count;
  int     rx_total;
  logic   req_q;
  logic   aborted;

  rx_chain_top uut (.*);

  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;  // 10 ns period

  ////////////////////////////////////////////////////////////
  // reference model, one call per valid sample
  ////////////////////////////////////////////////////////////
  function automatic void model_sample(input sample_t [`RX_CHANNELS-1:0] smp);
    sample_t src [2*`RX_CHANNELS];
    sample_t v;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      src[c]                = smp[c];                // raw sources first
      src[`RX_CHANNELS + c] = smp[c] - m_prev[c];    // then wrapped differences
      m_prev[c]             = smp[c];
    end
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      v = src[mux_config_i[c]];
      if ($signed(v) > $signed(thresh_high_i[c])) begin
        m_flag[c] = 1'b1;
      end else if ($signed(v) < $signed(thresh_low_i[c])) begin
        m_flag[c] = 1'b0;
      end
      if (m_capturing && m_flag[c] && m_count < `RX_BUFFER_DEPTH) begin
        exp_q.push_back({chan_id_t'(c), m_ts, v});  // id, timestamp, sample
        m_count++;
      end
    end
    if (m_capturing) begin
      m_ts++;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // output receiver and compare
  ////////////////////////////////////////////////////////////
  initial begin
    logic [7:0] idx;
    int         wait_left;
    idx       = '0;
    wait_left = 0;
    out_ack_i = 1'b0;
    forever begin
      @(posedge adc_clk);
      if (adc_reset) begin
        out_ack_i <= 1'b0;
      end else if (out_req_o != out_ack_i) begin  // phase 2 or 4 pending
        if (wait_left == 0) begin
          out_ack_i <= out_req_o;
          wait_left = delay_tab[idx] * ack_scale;
          idx++;
        end else begin
          wait_left--;
        end
      end
    end
  end

  always @(posedge adc_clk) begin
    record_t exp_rec;
    logic    exp_last;
    req_q <= out_req_o;
    if (!adc_reset && out_req_o && !req_q) begin  // new request
      rx_total++;
      if (out_ack_i) begin
        $display("out_req_o was raised while out_ack_i was still high");
        cmp_errs++;
      end
      if (exp_q.size() == 0) begin
        $display("unexpected record %h on the output port", out_data_o);
        cmp_errs++;
      end else begin
        exp_rec     = exp_q.pop_front();
        exp_last    = (exp_q.size() == 0);  // whole capture is queued before readout
        check_count += 2;
        if (out_data_o !== exp_rec) begin
          $display("Error: out_data_o is %h, expected %h", out_data_o, exp_rec);
          cmp_errs++;
        end
        if (out_last_o !== exp_last) begin
          $display("Error: out_last_o is %h, expected %h", out_last_o, exp_last);
          cmp_errs++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic drive_sample(input sample_t [`RX_CHANNELS-1:0] smp);
    @(posedge adc_clk);
    adc_data_i  <= smp;
    adc_valid_i <= 1'b1;
    model_sample(smp);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      adc_valid_i <= 1'b0;
    end
  endtask

  task automatic pulse(input int which);  // 0 start, 1 trigger, 2 stop
    @(posedge adc_clk);
    adc_valid_i <= 1'b0;
    start_i     <= (which == 0);
    trigger_i   <= (which == 1);
    stop_i      <= (which == 2);
    @(posedge adc_clk);
    start_i   <= 1'b0;
    trigger_i <= 1'b0;
    stop_i    <= 1'b0;
  endtask

  task automatic configure(input src_sel_t [`RX_CHANNELS-1:0] sel,
                           input sample_t  [`RX_CHANNELS-1:0] hi,
                           input sample_t  [`RX_CHANNELS-1:0] lo);
    @(posedge adc_clk);  // chain is idle here
    mux_config_i  <= sel;
    thresh_high_i <= hi;
    thresh_low_i  <= lo;
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: %s", what);
    main_errs++;
    aborted = 1'b1;
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (!capture_done_o && n < limit) begin
      @(posedge adc_clk);
      n++;
    end
    if (!capture_done_o) begin
      timeout_fail("capture_done_o never went high after the capture");
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 4 && n < limit) begin  // 4 quiet cycles, buffer back in idle
      @(posedge adc_clk);
      n++;
      quiet = (exp_q.size() == 0 && !out_req_o && !out_ack_i) ? quiet + 1 : 0;
    end
    if (quiet < 4) begin
      timeout_fail($sformatf("readout stalled, %0d records never arrived", exp_q.size()));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one capture from start to drained readout
  ////////////////////////////////////////////////////////////
  task automatic run_capture(input string name, input int n, input int start_kind,
                             input logic rnd, input logic use_stop, input logic poke);
    sample_t [`RX_CHANNELS-1:0] smp;
    int errs0;
    int rx0;
    errs0 = main_errs + cmp_errs;
    rx0   = rx_total;
    pulse(start_kind);
    m_capturing = 1'b1;  // timestamp and count restart
    m_ts        = '0;
    m_count     = 0;
    idle_cycles(4);
    check_count += 2;
    if (capture_active_o !== 1'b1) begin
      $display("Error: capture_active_o is %h, expected 1", capture_active_o);
      main_errs++;
    end
    if (capture_done_o !== 1'b0) begin  // cleared by the start
      $display("Error: capture_done_o is %h, expected 0", capture_done_o);
      main_errs++;
    end
    for (int i = 0; i < n; i++) begin
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        smp[c] = rnd ? sample_t'($random(seed)) : sample_t'(100 * i + 7 * c + 1);
      end
      drive_sample(smp);
    end
    idle_cycles(4);
    if (use_stop) begin
      pulse(2);
    end
    m_capturing = 1'b0;
    wait_done(200);
    if (poke && !aborted) begin  // start while records still go out
      pulse(0);
      idle_cycles(2);
      if (capture_active_o !== 1'b0) begin
        $display("Error: capture_active_o is %h, expected 0", capture_active_o);
        main_errs++;
      end
      if (capture_done_o !== 1'b1) begin
        $display("Error: capture_done_o is %h, expected 1", capture_done_o);
        main_errs++;
      end
    end
    if (!aborted) begin
      wait_drain(5000);
    end
    $display("test %-22s %0d records, %0d errors", name, rx_total - rx0,
             main_errs + cmp_errs - errs0);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed          = 32'h4a45;
    ack_scale     = 1;
    aborted       = 1'b0;
    m_prev        = '0;
    m_flag        = '0;
    m_ts          = '0;
    m_count       = 0;
    m_capturing   = 1'b0;
    adc_reset     = 1'b1;
    adc_data_i    = '0;
    adc_valid_i   = 1'b0;
    mux_config_i  = '0;
    thresh_high_i = '0;
    thresh_low_i  = '0;
    start_i       = 1'b0;
    trigger_i     = 1'b0;
    stop_i        = 1'b0;
    for (int i = 0; i < 256; i++) begin
      delay_tab[i] = int'($unsigned($random(seed)) % 6);
    end
    repeat (16) @(posedge adc_clk);
    adc_reset <= 1'b0;

    // thresholds at the minimum keep nearly everything
    configure({src_sel_t'(1), src_sel_t'(0)}, {`RX_CHANNELS{16'h8000}},
              {`RX_CHANNELS{16'h8000}});
    if (!aborted) run_capture("raw passthrough", 12, 0, 1'b0, 1'b1, 1'b0);
    configure({src_sel_t'(2), src_sel_t'(3)}, {`RX_CHANNELS{16'h8000}},
              {`RX_CHANNELS{16'h8000}});  // logical 0 takes diff of channel 1
    if (!aborted) run_capture("crossed differences", 16, 0, 1'b1, 1'b1, 1'b0);
    configure({src_sel_t'(1), src_sel_t'(0)}, {sample_t'(0), sample_t'(10000)},
              {sample_t'(-20000), sample_t'(-10000)});
    if (!aborted) run_capture("hysteresis", 40, 0, 1'b1, 1'b1, 1'b0);
    configure({src_sel_t'(1), src_sel_t'(0)}, {`RX_CHANNELS{16'h8000}},
              {`RX_CHANNELS{16'h8000}});
    if (!aborted) run_capture("self end at depth", 40, 0, 1'b0, 1'b0, 1'b0);
    if (!aborted) run_capture("trigger start", 8, 1, 1'b1, 1'b1, 1'b0);
    if (!aborted) run_capture("start during readout", 10, 0, 1'b1, 1'b1, 1'b1);
    configure({src_sel_t'(1), src_sel_t'(0)}, {`RX_CHANNELS{16'h7fff}},
              {`RX_CHANNELS{16'h7fff}});  // nothing passes
    if (!aborted) run_capture("nothing kept", 10, 0, 1'b0, 1'b1, 1'b0);
    configure({src_sel_t'(1), src_sel_t'(0)}, {`RX_CHANNELS{16'h8000}},
              {`RX_CHANNELS{16'h8000}});
    ack_scale = 3;  // acks up to 15 cycles late
    if (!aborted) run_capture("slow ack", 24, 0, 1'b1, 1'b1, 1'b0);

    $display("%0d checks, %0d records, %0d errors", check_count, rx_total,
             main_errs + cmp_errs);
    if (main_errs + cmp_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* rx_chain_top.f */
+incdir+hw
hw/rx_chain_pkg.sv
hw/sample_differentiator.sv
hw/channel_mux.sv
hw/sample_discriminator.sv
hw/capture_buffer.sv
hw/readout_port.sv
hw/rx_chain_top.sv
tb/rx_chain_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the receive chain testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 -f rx_chain_top.f --top-module rx_chain_tb -o Vrx_chain_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vrx_chain_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
